//--- project.f
ld_pkg.sv
ld_byte_sequencer.sv
ld_write_decoder.sv
ld_register_bank.sv
ld_imm_top.sv
ld_imm_properties.sv
ld_imm_tb.sv

//--- Makefile
# Verilator build, run and lint for the LD dd,nn pipeline

TOP := ld_imm_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module ld_imm_top \
		ld_pkg.sv ld_byte_sequencer.sv ld_write_decoder.sv \
		ld_register_bank.sv ld_imm_top.sv

clean:
	rm -rf obj_dir sim.log

//--- ld_imm_tb.sv
// ======================================================================
// LD dd,nn instructions always carry both immediate bytes here.
// Expected ld_done times assume no reset during the run.
// ======================================================================
module ld_imm_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam time CLK_PERIOD   = 100;
    localparam int  RESET_CYCLES = 10;
    localparam int  N_TABLE      = 12;
    localparam int  N_RANDOM     = 40;
    localparam int  MAX_GAP      = 3;
    localparam int  MAX_BYTES    = 3 * (N_TABLE + N_RANDOM);
    localparam time DONE_DELAY   = 3 * CLK_PERIOD + CLK_PERIOD / 2;
    localparam time TIMEOUT      = (RESET_CYCLES + MAX_BYTES * (MAX_GAP + 1) + 50) * CLK_PERIOD;

    typedef struct packed {
        ld_pkg::byte_t op;
        ld_pkg::byte_t lo;
        ld_pkg::byte_t hi;
        logic [1:0]    gap;
    } stim_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              byte_valid;
    ld_pkg::byte_t     byte_data;
    ld_pkg::reg_bank_t regs;
    logic              ld_done;

    ld_pkg::reg_bank_t model = '0;
    ld_pkg::reg_bank_t exp_regs;
    time               exp_time;
    time               done_time_q[$];
    ld_pkg::reg_bank_t done_regs_q[$];
    logic [31:0]       lcg_state = 32'd10;
    int                mismatch_errors = 0;
    int                done_mismatches = 0;
    int                other_errors = 0;
    int                ld_sent = 0;
    int                done_count = 0;

    // The gap 0 rows at the end keep several instructions in flight
    stim_t stim_table [N_TABLE] = '{
        '{8'h01, 8'h34, 8'h12, 2'd1},
        '{8'h11, 8'h78, 8'h56, 2'd1},
        '{8'h21, 8'hbc, 8'h9a, 2'd1},
        '{8'h31, 8'hf0, 8'hde, 2'd1},
        '{8'h00, 8'h00, 8'h00, 2'd2},
        '{8'h09, 8'h00, 8'h00, 2'd0},
        '{8'hc3, 8'h00, 8'h00, 2'd1},
        '{8'h11, 8'ha5, 8'h5a, 2'd2},
        '{8'h01, 8'h11, 8'h22, 2'd0},
        '{8'h11, 8'h33, 8'h44, 2'd0},
        '{8'h21, 8'h55, 8'h66, 2'd0},
        '{8'h31, 8'h77, 8'h88, 2'd0}
    };

    ld_imm_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .regs       (regs),
        .ld_done    (ld_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic is_ld_opcode(input ld_pkg::byte_t op);
        return op == 8'h01 || op == 8'h11 || op == 8'h21 || op == 8'h31;
    endfunction

    // Low byte into C, E, L or SP[7:0] and high byte into B, D, H or SP[15:8]
    function automatic ld_pkg::reg_bank_t apply_ld(input ld_pkg::reg_bank_t cur,
                                                   input ld_pkg::byte_t op,
                                                   input ld_pkg::byte_t lo,
                                                   input ld_pkg::byte_t hi);
        ld_pkg::reg_bank_t nxt;
        nxt = cur;
        case (op)
            8'h01: begin
                nxt.b = hi;
                nxt.c = lo;
            end
            8'h11: begin
                nxt.d = hi;
                nxt.e = lo;
            end
            8'h21: begin
                nxt.h = hi;
                nxt.l = lo;
            end
            8'h31: nxt.sp = {hi, lo};
            default: nxt = cur;
        endcase
        return nxt;
    endfunction

    task automatic drive_byte(input ld_pkg::byte_t b);
        @(posedge clk);
        byte_valid <= 1'b1;
        byte_data  <= b;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            byte_valid <= 1'b0;
        end
    endtask

    task automatic send_instr(input stim_t s);
        drive_byte(s.op);
        idle(int'(s.gap));
        if (is_ld_opcode(s.op)) begin
            drive_byte(s.lo);
            idle(int'(s.gap));
            drive_byte(s.hi);
            // Three edges to the write, sampled on the following falling edge
            model = apply_ld(model, s.op, s.lo, s.hi);
            done_time_q.push_back($time + DONE_DELAY);
            done_regs_q.push_back(model);
            ld_sent++;
            idle(int'(s.gap));
        end
    endtask

    // ==================================================================
    // ld_done monitor
    // ==================================================================

    always @(negedge clk) begin
        if (rst_n && ld_done) begin
            done_count++;
            assert (done_time_q.size() != 0) else begin
                other_errors++;
                $display("ld_done pulsed at %0t with no LD instruction outstanding", $time);
            end
            if (done_time_q.size() != 0) begin
                exp_time = done_time_q.pop_front();
                exp_regs = done_regs_q.pop_front();
                assert ($time == exp_time) else begin
                    done_mismatches++;
                    $display("MISMATCH at %0t: ld_done expected at %0t", $time, exp_time);
                end
                assert (regs == exp_regs) else begin
                    done_mismatches++;
                    $display("MISMATCH at %0t: regs %h, expected %h", $time, regs, exp_regs);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: run did not finish within %0t", TIMEOUT);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ==================================================================
    // Stimulus
    // ==================================================================

    initial begin
        stim_t       s;
        logic [31:0] r;
        rst_n      = 1'b0;
        byte_valid = 1'b0;
        byte_data  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (regs == '0 && ld_done == 1'b0) else begin
            mismatch_errors++;
            $display("MISMATCH at %0t: regs %h ld_done %b after reset", $time, regs, ld_done);
        end

        foreach (stim_table[i]) begin
            send_instr(stim_table[i]);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            r = next_rand();
            // Mostly LD dd,nn with some arbitrary opcodes mixed in
            s.op  = (r[31:30] != 2'b00) ? {2'b00, r[21:20], 4'b0001} : r[15:8];
            r = next_rand();
            s.lo  = r[23:16];
            s.hi  = r[15:8];
            s.gap = r[29:28];
            send_instr(s);
        end
        idle(1);

        while (done_time_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        assert (regs == model) else begin
            mismatch_errors++;
            $display("MISMATCH at %0t: final regs %h, expected %h", $time, regs, model);
        end
        assert (done_count == ld_sent) else begin
            mismatch_errors++;
            $display("MISMATCH at %0t: %0d ld_done pulses for %0d LD instructions",
                     $time, done_count, ld_sent);
        end

        $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatch_errors + done_mismatches, other_errors, UUT.u_props.assert_fails);
        if (mismatch_errors + done_mismatches + other_errors + UUT.u_props.assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- ld_imm_properties.sv
// ======================================================================
// Bound into ld_imm_top and reads the sequencer state directly.
// ======================================================================
module ld_imm_properties (
    input logic               clk,
    input logic               rst_n,
    input ld_pkg::seq_state_e state,
    input ld_pkg::seq_item_t  item,
    input ld_pkg::reg_wr_t    wr,
    input logic               ld_done
);
    timeunit 1ns;
    timeprecision 1ns;

    int assert_fails = 0;

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        wr.valid |-> $onehot(wr.sel))
    else begin
        assert_fails++;
        $error("Write enable is not one-hot on a valid write");
    end

    a_sel_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !wr.valid |-> wr.sel == '0)
    else begin
        assert_fails++;
        $error("Write enable is set without a valid write");
    end

    // ld_done follows the final write of an instruction by one cycle
    a_done_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        ld_done |-> $past(wr.valid & wr.last))
    else begin
        assert_fails++;
        $error("ld_done without a preceding last write");
    end

    a_no_item_from_opcode: assert property (@(posedge clk) disable iff (!rst_n)
        item.valid |-> $past(state) != ld_pkg::OPCODE)
    else begin
        assert_fails++;
        $error("Sequencer emitted an item from the OPCODE state");
    end

endmodule

bind ld_imm_top ld_imm_properties u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .state   (u_sequencer.state),
    .item    (seq_item),
    .wr      (reg_wr),
    .ld_done (ld_done)
);

//--- ld_imm_top.sv
// ====================================================================
// A byte strobe reaches regs three clock edges later.
// ====================================================================
module ld_imm_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              byte_valid,
    input  ld_pkg::byte_t     byte_data,
    output ld_pkg::reg_bank_t regs,
    output logic              ld_done
);

    ld_pkg::seq_item_t seq_item;
    ld_pkg::reg_wr_t   reg_wr;

    ld_byte_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .item       (seq_item)
    );

    ld_write_decoder u_decoder (
        .clk   (clk),
        .rst_n (rst_n),
        .item  (seq_item),
        .wr    (reg_wr)
    );

    ld_register_bank u_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (reg_wr),
        .regs    (regs),
        .ld_done (ld_done)
    );

endmodule

//--- ld_register_bank.sv
// ====================================================================
// Each write updates one byte. ld_done pulses on the final write.
// ====================================================================
module ld_register_bank (
    input  logic              clk,
    input  logic              rst_n,
    input  ld_pkg::reg_wr_t   wr,
    output ld_pkg::reg_bank_t regs,
    output logic              ld_done
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs    <= '0;
            ld_done <= 1'b0;
        end else begin
            ld_done <= wr.valid & wr.last;

            if (wr.valid) begin
                // Low bank
                if (wr.sel[ld_pkg::SEL_C]) begin
                    regs.c <= wr.data;
                end
                if (wr.sel[ld_pkg::SEL_E]) begin
                    regs.e <= wr.data;
                end
                if (wr.sel[ld_pkg::SEL_L]) begin
                    regs.l <= wr.data;
                end
                if (wr.sel[ld_pkg::SEL_SP_LO]) begin
                    regs.sp[7:0] <= wr.data;
                end

                // High bank
                if (wr.sel[ld_pkg::SEL_B]) begin
                    regs.b <= wr.data;
                end
                if (wr.sel[ld_pkg::SEL_D]) begin
                    regs.d <= wr.data;
                end
                if (wr.sel[ld_pkg::SEL_H]) begin
                    regs.h <= wr.data;
                end
                if (wr.sel[ld_pkg::SEL_SP_HI]) begin
                    regs.sp[15:8] <= wr.data;
                end
            end
        end
    end

endmodule

//--- ld_write_decoder.sv
// ====================================================================
// One item in gives exactly one one-hot write enable, one cycle later.
// ====================================================================
module ld_write_decoder (
    input  logic              clk,
    input  logic              rst_n,
    input  ld_pkg::seq_item_t item,
    output ld_pkg::reg_wr_t   wr
);

    logic [2:0]       low_pos;
    logic [2:0]       high_pos;
    ld_pkg::reg_sel_t sel;

    // The pair picks one enable in each bank
    always_comb begin
        case (item.pair)
            2'd0: begin
                low_pos  = ld_pkg::SEL_C;
                high_pos = ld_pkg::SEL_B;
            end
            2'd1: begin
                low_pos  = ld_pkg::SEL_E;
                high_pos = ld_pkg::SEL_D;
            end
            2'd2: begin
                low_pos  = ld_pkg::SEL_L;
                high_pos = ld_pkg::SEL_H;
            end
            default: begin
                low_pos  = ld_pkg::SEL_SP_LO;
                high_pos = ld_pkg::SEL_SP_HI;
            end
        endcase
    end

    // The phase then picks the bank
    always_comb begin
        sel = '0;
        if (item.valid) begin
            sel[item.high ? high_pos : low_pos] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr <= '0;
        end else begin
            wr.valid <= item.valid;
            // High byte closes the instruction
            wr.last  <= item.valid & item.high;
            wr.sel   <= sel;
            wr.data  <= item.data;
        end
    end

endmodule

//--- ld_byte_sequencer.sv
// ====================================================================
// Bytes arrive as single-cycle strobes with no back-pressure.
// Any opcode other than LD dd,nn is treated as a one-byte instruction.
// ====================================================================
module ld_byte_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              byte_valid,
    input  ld_pkg::byte_t     byte_data,
    output ld_pkg::seq_item_t item
);

    ld_pkg::seq_state_e state;
    ld_pkg::seq_state_e state_next;
    ld_pkg::pair_t      pair_q;
    ld_pkg::pair_t      pair_next;
    ld_pkg::seq_item_t  item_next;
    logic               is_ld_dd_nn;

    assign is_ld_dd_nn =
        (byte_data & ld_pkg::LD_DD_NN_MASK) == ld_pkg::LD_DD_NN_MATCH;

    // ================================================================
    // Next-state logic
    // ================================================================

    always_comb begin
        state_next = state;
        pair_next  = pair_q;
        item_next  = '0;

        if (byte_valid) begin
            case (state)
                ld_pkg::OPCODE: begin
                    // Opcode bytes only advance the phase, nothing is emitted
                    if (is_ld_dd_nn) begin
                        pair_next  = byte_data[ld_pkg::DD_LSB +: $bits(ld_pkg::pair_t)];
                        state_next = ld_pkg::IMM_LOW;
                    end
                end

                ld_pkg::IMM_LOW: begin
                    item_next.valid = 1'b1;
                    item_next.high  = 1'b0;
                    item_next.pair  = pair_q;
                    item_next.data  = byte_data;
                    state_next      = ld_pkg::IMM_HIGH;
                end

                ld_pkg::IMM_HIGH: begin
                    item_next.valid = 1'b1;
                    item_next.high  = 1'b1;
                    item_next.pair  = pair_q;
                    item_next.data  = byte_data;
                    state_next      = ld_pkg::OPCODE;
                end

                default: begin
                    state_next = ld_pkg::OPCODE;
                end
            endcase
        end
    end

    // ================================================================
    // Registers
    // ================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ld_pkg::OPCODE;
            pair_q <= '0;
            item   <= '0;
        end else begin
            state  <= state_next;
            pair_q <= pair_next;
            item   <= item_next;
        end
    end

endmodule

//--- ld_pkg.sv
// ====================================================================
// Shared widths, LD dd,nn opcode constants and stage structs.
// Pair encoding follows the dd field: 0 BC, 1 DE, 2 HL, 3 SP.
// ====================================================================
package ld_pkg;

    // ================================================================
    // Basic types
    // ================================================================

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [1:0]  pair_t;

    // One-hot register write enable, one bit per target byte
    typedef logic [7:0]  reg_sel_t;

    // ================================================================
    // Opcode recognition
    // ================================================================

    // LD dd,nn is 00dd0001, so only the dd bits are free
    localparam byte_t LD_DD_NN_MASK  = 8'b1100_1111;
    localparam byte_t LD_DD_NN_MATCH = 8'b0000_0001;
    localparam int    DD_LSB         = 4;

    // ================================================================
    // Write enable positions
    // ================================================================

    // Low bank takes the first immediate byte
    localparam logic [2:0] SEL_C     = 3'd0;
    localparam logic [2:0] SEL_E     = 3'd1;
    localparam logic [2:0] SEL_L     = 3'd2;
    localparam logic [2:0] SEL_SP_LO = 3'd3;

    // High bank takes the second immediate byte
    localparam logic [2:0] SEL_B     = 3'd4;
    localparam logic [2:0] SEL_D     = 3'd5;
    localparam logic [2:0] SEL_H     = 3'd6;
    localparam logic [2:0] SEL_SP_HI = 3'd7;

    // ================================================================
    // Stage types
    // ================================================================

    typedef enum logic [1:0] {
        OPCODE,
        IMM_LOW,
        IMM_HIGH
    } seq_state_e;

    // Stage 1 output, one per immediate byte
    typedef struct packed {
        logic  valid;
        logic  high;
        pair_t pair;
        byte_t data;
    } seq_item_t;

    // Stage 2 output, one register write
    typedef struct packed {
        logic     valid;
        logic     last;
        reg_sel_t sel;
        byte_t    data;
    } reg_wr_t;

    typedef struct packed {
        byte_t b;
        byte_t c;
        byte_t d;
        byte_t e;
        byte_t h;
        byte_t l;
        word_t sp;
    } reg_bank_t;

endpackage
